// ==== hw/bridge_pkg.sv ====
package bridge_pkg;

  // bus widths
  localparam int addr_w = 32;
  localparam int data_w = 32;

  // queue position field below the active flag
  localparam int pos_w = 31;

  // thread header skipped to reach the body
  localparam logic [addr_w-1:0] thread_header_space = 16;

  // bit 31 active flag, bits 30..0 position
  // all zeros means not active
  typedef logic [data_w-1:0] cpu_index_t;

  // core sequencer states seen by the bridge
  typedef enum logic [4:0] {
    wait_for_start,
    start_begin,
    start_read_cmd,
    start_read_cmd_p,
    read_cond,
    read_cond_p,
    read_src1,
    read_src1_p,
    read_src0,
    read_src0_p,
    read_dst,
    write_reg_ip,
    write_dst,
    write_dst_p,
    write_src1,
    write_src0,
    write_cond,
    alu_begin,
    finish_begin,
    finish_end,
    state_other
  } cpu_state_t;

  // messages on the shared dispatcher bus
  typedef enum logic [7:0] {
    msg_none      = 8'h00,
    msg_reset     = 8'h01,
    msg_start     = 8'h02,
    msg_end       = 8'h03,
    msg_fork_done = 8'h04,
    msg_stop_done = 8'h05
  } cpu_msg_t;

  // other core's index relative to ours
  typedef enum logic [1:0] {
    rel_none   = 2'b00,
    rel_lower  = 2'b01,
    rel_higher = 2'b10,
    rel_same   = 2'b11
  } ind_rel_t;

  // reset sequencer steps
  typedef enum logic [2:0] {
    step_clear  = 3'd0,
    step_check  = 3'd1,
    step_load   = 3'd2,
    step_pulse  = 3'd3,
    step_online = 3'd4,
    step_done   = 3'd5
  } rst_step_t;

endpackage

// ==== hw/bridge_to_outside.sv ====
module bridge_to_outside (
  input  logic                          clk,
  input  logic                          ext_rst_b,
  input  bridge_pkg::cpu_state_t        state,
  input  logic [bridge_pkg::addr_w-1:0] addr_in,
  input  logic [bridge_pkg::data_w-1:0] data_in,
  input  logic                          read_q,
  input  logic                          write_q,
  input  logic                          bus_busy_in,
  input  bridge_pkg::cpu_index_t        ext_cpu_index,
  input  logic                          ext_next_cpu_q,
  input  bridge_pkg::cpu_msg_t          ext_cpu_msg_in,
  output logic [bridge_pkg::addr_w-1:0] base_addr,
  output logic [bridge_pkg::addr_w-1:0] base_addr_data,
  output bridge_pkg::ind_rel_t          cpu_ind_rel,
  output logic                          bus_busy_out,
  output logic                          disp_online,
  output logic                          next_state,
  output logic                          rst,
  output logic                          ext_rst_e,
  output logic                          ext_next_cpu_e,
  output logic                          ext_dispatcher_q,
  output bridge_pkg::cpu_msg_t          ext_cpu_msg,
  output logic                          ext_read_q,
  output logic                          ext_write_q
);

  import bridge_pkg::*;

  // sequencer strobes and levels
  reset_seq_if seq_bus ();

  cpu_index_t own_index;
  logic       index_match;
  logic       grant_pulse;

  reset_sequencer u_reset_sequencer (
    .clk          (clk),
    .ext_rst_b    (ext_rst_b),
    .state        (state),
    .rst          (rst),
    .ext_rst_e    (ext_rst_e),
    .bus_busy_out (bus_busy_out),
    .seq          (seq_bus.seq)
  );

  queue_position u_queue_position (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .ext_cpu_index  (ext_cpu_index),
    .ext_cpu_msg_in (ext_cpu_msg_in),
    .state          (state),
    .grant_pulse    (grant_pulse),
    .seq            (seq_bus.user),
    .own_index      (own_index),
    .index_match    (index_match)
  );

  dispatch_arbiter u_dispatch_arbiter (
    .clk              (clk),
    .ext_rst_b        (ext_rst_b),
    .state            (state),
    .addr_in          (addr_in),
    .data_in          (data_in),
    .read_q           (read_q),
    .write_q          (write_q),
    .bus_busy_in      (bus_busy_in),
    .ext_next_cpu_q   (ext_next_cpu_q),
    .ext_cpu_index    (ext_cpu_index),
    .own_index        (own_index),
    .index_match      (index_match),
    .ext_cpu_msg_in   (ext_cpu_msg_in),
    .seq              (seq_bus.user),
    .base_addr        (base_addr),
    .base_addr_data   (base_addr_data),
    .cpu_ind_rel      (cpu_ind_rel),
    .disp_online      (disp_online),
    .next_state       (next_state),
    .ext_next_cpu_e   (ext_next_cpu_e),
    .ext_dispatcher_q (ext_dispatcher_q),
    .ext_cpu_msg      (ext_cpu_msg),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q),
    .grant_pulse      (grant_pulse)
  );

endmodule

// ==== hw/dispatch_arbiter.sv ====
module dispatch_arbiter (
  input  logic                          clk,
  input  logic                          ext_rst_b,
  input  bridge_pkg::cpu_state_t        state,
  input  logic [bridge_pkg::addr_w-1:0] addr_in,
  input  logic [bridge_pkg::addr_w-1:0] data_in,
  input  logic                          read_q,
  input  logic                          write_q,
  input  logic                          bus_busy_in,
  input  logic                          ext_next_cpu_q,
  input  bridge_pkg::cpu_index_t        ext_cpu_index,
  input  bridge_pkg::cpu_index_t        own_index,
  input  logic                          index_match,
  input  bridge_pkg::cpu_msg_t          ext_cpu_msg_in,
  reset_seq_if.user                     seq,
  output logic [bridge_pkg::addr_w-1:0] base_addr,
  output logic [bridge_pkg::addr_w-1:0] base_addr_data,
  output bridge_pkg::ind_rel_t          cpu_ind_rel,
  output logic                          disp_online,
  output logic                          next_state,
  output logic                          ext_next_cpu_e,
  output logic                          ext_dispatcher_q,
  output bridge_pkg::cpu_msg_t          ext_cpu_msg,
  output logic                          ext_read_q,
  output logic                          ext_write_q,
  output logic                          grant_pulse
);

  import bridge_pkg::*;

  logic             rd_state;
  logic             wr_state;
  logic             grant;
  logic             ack_msg;
  logic             disp_q;
  logic [pos_w-1:0] ext_pos;
  logic [pos_w-1:0] own_pos;

  // states that read or write through the bus
  assign rd_state = state inside {start_read_cmd, start_read_cmd_p, read_cond, read_cond_p,
                                  read_src1, read_src1_p, read_src0, read_src0_p, read_dst};
  assign wr_state = state inside {write_reg_ip, write_dst, write_dst_p, write_src1,
                                  write_src0, write_cond};

  assign grant   = ext_next_cpu_q && index_match;
  assign ack_msg = (ext_cpu_msg_in == msg_fork_done) || (ext_cpu_msg_in == msg_stop_done);

  assign ext_pos = ext_cpu_index[pos_w-1:0];
  assign own_pos = own_index[pos_w-1:0];

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      cpu_ind_rel    <= rel_none;
      disp_online    <= 1'b0;
      next_state     <= 1'b0;
      ext_next_cpu_e <= 1'b0;
      disp_q         <= 1'b0;
      ext_cpu_msg    <= msg_none;
    end else if (seq.in_reset) begin
      cpu_ind_rel    <= rel_none;
      disp_online    <= 1'b0;
      next_state     <= 1'b0;
      ext_next_cpu_e <= 1'b0;
      // carried over so the level continues past step_done
      disp_q         <= seq.dispatcher_ready;
      // announce the freshly loaded position
      ext_cpu_msg    <= seq.load_index ? msg_reset : msg_none;
    end else begin
      // message and next_state are single-cycle strobes
      ext_cpu_msg <= msg_none;
      next_state  <= 1'b0;

      // relation flags track every offered index, busy or not
      if (ext_next_cpu_q) begin
        if (ext_pos < own_pos) begin
          cpu_ind_rel <= rel_lower;
        end else if (ext_pos > own_pos) begin
          cpu_ind_rel <= rel_higher;
        end else if (ext_cpu_index == own_index) begin
          cpu_ind_rel <= rel_same;
        end
      end else if (ext_next_cpu_e) begin
        cpu_ind_rel <= rel_none;
      end

      if (!bus_busy_in) begin
        // bus release once the request goes away
        if (disp_online) begin
          if (read_q || write_q) begin
            ext_next_cpu_e <= 1'b1;
          end else if (ext_next_cpu_e) begin
            ext_next_cpu_e <= 1'b0;
            disp_online    <= 1'b0;
          end
        end

        if (grant) begin
          disp_online <= 1'b1;
          case (state)
            wait_for_start: begin
              ext_cpu_msg    <= msg_start;
              ext_next_cpu_e <= 1'b1;
              next_state     <= 1'b1;
              base_addr      <= addr_in + thread_header_space;
              // no separate data segment, data follows the code
              if (data_in == '0) begin
                base_addr_data <= addr_in + thread_header_space;
              end else begin
                base_addr_data <= data_in + thread_header_space;
              end
            end
            finish_begin: begin
              ext_cpu_msg    <= msg_end;
              ext_next_cpu_e <= 1'b1;
              next_state     <= 1'b1;
            end
            default: begin
              if (rd_state || wr_state) begin
                disp_q <= 1'b1;
              end
            end
          endcase
        end else begin
          case (state)
            // fork or stop finished elsewhere, hand the bus on
            alu_begin: begin
              if (ack_msg) begin
                ext_next_cpu_e <= 1'b1;
              end
            end
            start_begin, finish_end: begin
            end
            default: begin
              disp_q <= rd_state || wr_state;
            end
          endcase
        end
      end

      // finished thread drops off the bus ahead of the restart
      if (state == finish_end) begin
        disp_online <= 1'b0;
      end
    end
  end

  // sequencer owns the level until step_done
  assign ext_dispatcher_q = seq.in_reset ? seq.dispatcher_ready : disp_q;

  // requests pass only in bus states while we hold the bus
  assign ext_read_q  = (rd_state && disp_online) ? read_q : 1'b0;
  assign ext_write_q = (wr_state && disp_online) ? write_q : 1'b0;

  assign grant_pulse = ext_next_cpu_e;

endmodule

// ==== hw/queue_position.sv ====
module queue_position (
  input  logic                   clk,
  input  logic                   ext_rst_b,
  input  bridge_pkg::cpu_index_t ext_cpu_index,
  input  bridge_pkg::cpu_msg_t   ext_cpu_msg_in,
  input  bridge_pkg::cpu_state_t state,
  input  logic                   grant_pulse,
  reset_seq_if.user              seq,
  output bridge_pkg::cpu_index_t own_index,
  output logic                   index_match
);

  import bridge_pkg::*;

  logic             ext_active;
  logic             own_active;
  logic [pos_w-1:0] ext_pos;
  logic [pos_w-1:0] own_pos;

  assign ext_active = ext_cpu_index[data_w-1];
  assign own_active = own_index[data_w-1];
  assign ext_pos    = ext_cpu_index[pos_w-1:0];
  assign own_pos    = own_index[pos_w-1:0];

  // index currently on the bus is ours
  assign index_match = (ext_cpu_index == own_index);

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      own_index <= '0;
    end else if (seq.in_reset) begin
      // position taken from the bus at power-up
      if (seq.load_index) begin
        own_index <= ext_cpu_index;
      end
      // finished thread leaves the queue
      if (seq.clear_index) begin
        own_index <= '0;
      end
    end else if (index_match) begin
      // first thread on an idle core becomes head of queue
      if ((own_index == '0) && (state == start_begin)) begin
        own_index <= {1'b1, pos_w'(0)};
      end
    end else if (!grant_pulse) begin
      // a grant in flight means the bus message is our own broadcast
      if (ext_active) begin
        // someone ahead of us finished, move up
        if ((ext_cpu_msg_in == msg_end) && own_active && (ext_pos < own_pos)) begin
          own_index[pos_w-1:0] <= own_pos - pos_w'(1);
        end
      end else if (ext_cpu_msg_in == msg_start) begin
        // new thread joins the queue
        if (own_active) begin
          own_index[pos_w-1:0] <= own_pos + pos_w'(1);
        end else begin
          own_index[pos_w-1:0] <= own_pos - pos_w'(1);
        end
      end
    end
  end

endmodule

// ==== hw/reset_seq_if.sv ====
interface reset_seq_if;

  // high while the sequence runs, low from step_done
  logic in_reset;

  // index load strobe, power-up path
  logic load_index;

  // index clear strobe, restart after a finished thread
  logic clear_index;

  // dispatcher may be reported present
  logic dispatcher_ready;

  modport seq (
    output in_reset,
    output load_index,
    output clear_index,
    output dispatcher_ready
  );

  modport user (
    input in_reset,
    input load_index,
    input clear_index,
    input dispatcher_ready
  );

endinterface

// ==== hw/reset_sequencer.sv ====
module reset_sequencer (
  input  logic                   clk,
  input  logic                   ext_rst_b,
  input  bridge_pkg::cpu_state_t state,
  output logic                   rst,
  output logic                   ext_rst_e,
  output logic                   bus_busy_out,
  reset_seq_if.seq               seq
);

  import bridge_pkg::*;

  rst_step_t step;

  // first edge after release only enters step_clear
  logic start_pending;

  // set when the run was started by finish_end
  logic from_finish;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      step          <= step_clear;
      start_pending <= 1'b1;
      from_finish   <= 1'b0;
      rst           <= 1'b0;
      ext_rst_e     <= 1'b0;
      bus_busy_out  <= 1'b0;
    end else begin
      // one-cycle pulses while sitting in step_pulse
      rst          <= (step == step_load);
      bus_busy_out <= (step == step_load);
      // external reset skipped on a finish restart
      ext_rst_e    <= (step == step_load) && !from_finish && (state != finish_end);

      if (start_pending) begin
        start_pending <= 1'b0;
      end else begin
        case (step)
          step_clear:  step <= step_check;
          step_check:  step <= step_load;
          step_load:   step <= step_pulse;
          step_pulse:  step <= step_online;
          step_online: step <= step_done;
          step_done: begin
            // thread ended, run the sequence again
            if (state == finish_end) begin
              step        <= step_clear;
              from_finish <= 1'b1;
            end
          end
          default:     step <= step_clear;
        endcase
      end
    end
  end

  assign seq.in_reset = (step != step_done);

  // strobes sit one step early so the index changes on the edge entering step_load
  assign seq.load_index  = (step == step_check) && !from_finish;
  assign seq.clear_index = (step == step_check) && from_finish;

  assign seq.dispatcher_ready = (step == step_online) || (step == step_done);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

out=$(verilator --binary --timing --top-module tb_bridge -f sim.f -o tb_bridge && \
  ./obj_dir/tb_bridge)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx '=== PASS ===' && echo "simulation passed" && exit 0 || \
  { echo "simulation failed"; exit 1; }

// ==== sim.f ====
hw/bridge_pkg.sv
hw/reset_seq_if.sv
hw/reset_sequencer.sv
hw/queue_position.sv
hw/dispatch_arbiter.sv
hw/bridge_to_outside.sv
testbench/tb_bridge.sv

// ==== testbench/bridge_tests.txt ====
# op state addr data rd wr busy index next_q msg flags rel exp_msg base base_data mask (hex)
# flags bit0..8: bus_busy_out disp_online next_state rst ext_rst_e ext_next_cpu_e ext_dispatcher_q ext_read_q ext_write_q; expected = outputs seen during that record's cycle
# reset and power-up sequence
0 14 00000000 00000000 0 0 0 80000002 0 00 000 0 00 00000000 00000000 7
1 14 00000000 00000000 0 0 0 80000002 0 00 000 0 00 00000000 00000000 7
1 14 00000000 00000000 0 0 0 80000002 0 00 000 0 00 00000000 00000000 7
1 14 00000000 00000000 0 0 0 80000002 0 00 000 0 00 00000000 00000000 7
1 14 00000000 00000000 0 0 0 80000002 0 00 000 0 01 00000000 00000000 7
1 14 00000000 00000000 0 0 0 80000002 0 00 019 0 00 00000000 00000000 7
1 14 00000000 00000000 0 0 0 80000002 0 00 040 0 00 00000000 00000000 7
# thread start with data_in zero, then read gating and release
1 00 00001000 00000000 0 0 0 80000002 1 00 040 0 00 00000000 00000000 7
1 08 00000000 00000000 1 0 0 80000002 0 00 0e6 3 02 00001010 00001010 f
1 00 00000000 00000000 1 0 0 80000002 0 00 062 0 00 00000000 00000000 7
1 11 00000000 00000000 1 0 0 80000002 0 00 022 0 00 00000000 00000000 7
1 08 00000000 00000000 0 0 0 80000002 0 00 022 0 00 00000000 00000000 7
# queue tracking: END from position 1, relation probes, START from inactive core
1 14 00000000 00000000 0 0 0 80000001 0 03 040 0 00 00000000 00000000 7
1 14 00000000 00000000 0 0 0 80000003 1 00 000 0 00 00000000 00000000 7
1 14 00000000 00000000 0 0 0 80000000 1 00 000 2 00 00000000 00000000 7
1 14 00000000 00000000 0 0 0 00000005 0 02 000 1 00 00000000 00000000 7
1 00 00002000 00004000 0 0 0 80000002 1 00 000 1 00 00000000 00000000 7
1 0f 00000000 00000000 0 1 0 80000002 0 00 126 3 02 00002010 00004010 f
1 14 00000000 00000000 0 0 0 80000002 0 00 062 0 00 00000000 00000000 7
# acknowledges and busy hold
1 11 00000000 00000000 0 0 0 80000002 0 04 000 0 00 00000000 00000000 7
1 14 00000000 00000000 0 0 1 80000002 1 00 020 0 00 00000000 00000000 7
1 14 00000000 00000000 0 0 0 80000002 1 00 020 3 00 00000000 00000000 7
1 14 00000000 00000000 0 0 0 80000002 0 00 022 3 00 00000000 00000000 7
1 11 00000000 00000000 0 0 0 80000002 0 05 000 0 00 00000000 00000000 7
# finish and restart without external reset
1 12 00000000 00000000 0 0 0 80000002 1 00 020 0 00 00000000 00000000 7
1 13 00000000 00000000 0 0 0 80000002 0 00 026 3 03 00000000 00000000 7
1 14 00000000 00000000 0 0 0 80000002 0 00 000 0 00 00000000 00000000 7
1 14 00000000 00000000 0 0 0 80000002 0 00 000 0 00 00000000 00000000 7
1 14 00000000 00000000 0 0 0 80000002 0 00 000 0 00 00000000 00000000 7
1 14 00000000 00000000 0 0 0 80000002 0 00 009 0 00 00000000 00000000 7
1 14 00000000 00000000 0 0 0 80000002 0 00 040 0 00 00000000 00000000 7
1 01 00000000 00000000 0 0 0 00000000 0 00 040 0 00 00000000 00000000 7
1 00 00003000 00000000 0 0 0 80000000 1 00 040 0 00 00000000 00000000 7
1 14 00000000 00000000 0 0 0 80000000 0 00 066 3 02 00003010 00003010 f
1 14 00000000 00000000 0 0 0 80000000 0 00 000 0 00 00000000 00000000 7

// ==== testbench/tb_bridge.sv ====
module tb_bridge;

  timeunit 1ns;
  timeprecision 100ps;

  import bridge_pkg::*;

  localparam int clk_period        = 4;
  localparam int reset_cycles      = 5;
  localparam int cycles_per_record = 40;
  localparam int max_records       = 64;
  localparam int num_fields        = 16;

  // column positions within one test record
  localparam int f_op        = 0;
  localparam int f_state     = 1;
  localparam int f_addr      = 2;
  localparam int f_data      = 3;
  localparam int f_rd        = 4;
  localparam int f_wr        = 5;
  localparam int f_busy      = 6;
  localparam int f_index     = 7;
  localparam int f_next_q    = 8;
  localparam int f_msg       = 9;
  localparam int f_flags     = 10;
  localparam int f_rel       = 11;
  localparam int f_exp_msg   = 12;
  localparam int f_base      = 13;
  localparam int f_base_data = 14;
  localparam int f_mask      = 15;

  logic             clk;
  logic             ext_rst_b;
  cpu_state_t       state;
  logic [addr_w-1:0] addr_in;
  logic [data_w-1:0] data_in;
  logic             read_q;
  logic             write_q;
  logic             bus_busy_in;
  cpu_index_t       ext_cpu_index;
  logic             ext_next_cpu_q;
  cpu_msg_t         ext_cpu_msg_in;
  logic [addr_w-1:0] base_addr;
  logic [addr_w-1:0] base_addr_data;
  ind_rel_t         cpu_ind_rel;
  logic             bus_busy_out;
  logic             disp_online;
  logic             next_state;
  logic             rst;
  logic             ext_rst_e;
  logic             ext_next_cpu_e;
  logic             ext_dispatcher_q;
  cpu_msg_t         ext_cpu_msg;
  logic             ext_read_q;
  logic             ext_write_q;

  logic [31:0] records [max_records][num_fields];
  int          n_records;
  int          errors;
  int          checks;
  int          current;
  bit          records_ready;

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  bridge_to_outside u_dut (
    .clk              (clk),
    .ext_rst_b        (ext_rst_b),
    .state            (state),
    .addr_in          (addr_in),
    .data_in          (data_in),
    .read_q           (read_q),
    .write_q          (write_q),
    .bus_busy_in      (bus_busy_in),
    .ext_cpu_index    (ext_cpu_index),
    .ext_next_cpu_q   (ext_next_cpu_q),
    .ext_cpu_msg_in   (ext_cpu_msg_in),
    .base_addr        (base_addr),
    .base_addr_data   (base_addr_data),
    .cpu_ind_rel      (cpu_ind_rel),
    .bus_busy_out     (bus_busy_out),
    .disp_online      (disp_online),
    .next_state       (next_state),
    .rst              (rst),
    .ext_rst_e        (ext_rst_e),
    .ext_next_cpu_e   (ext_next_cpu_e),
    .ext_dispatcher_q (ext_dispatcher_q),
    .ext_cpu_msg      (ext_cpu_msg),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q)
  );

  // comment lines start with '#'
  task automatic load_records();
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] fld [num_fields];
    fd = $fopen("testbench/bridge_tests.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the test file testbench/bridge_tests.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                        fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
                        fld[15]);
          if (cnt != num_fields) begin
            errors++;
            $display("malformed test record: %s", line);
          end else if (n_records >= max_records) begin
            errors++;
            $display("too many test records, the rest is ignored");
          end else begin
            for (int k = 0; k < num_fields; k++) begin
              records[n_records][k] = fld[k];
            end
            n_records++;
          end
        end
      end
      $fclose(fd);
      if (n_records == 0) begin
        errors++;
        $display("the test file holds no records");
      end
    end
  endtask

  // op 0 holds the reset, op 1 is one normal cycle
  task automatic drive_record(int i);
    ext_rst_b      = (records[i][f_op] == 0);
    state          = cpu_state_t'(records[i][f_state][4:0]);
    addr_in        = records[i][f_addr];
    data_in        = records[i][f_data];
    read_q         = records[i][f_rd][0];
    write_q        = records[i][f_wr][0];
    bus_busy_in    = records[i][f_busy][0];
    ext_cpu_index  = records[i][f_index];
    ext_next_cpu_q = records[i][f_next_q][0];
    ext_cpu_msg_in = cpu_msg_t'(records[i][f_msg][7:0]);
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0d ns: %s expected %b, got %b (record %0d)",
               $time, name, exp, act, current);
    end
  endtask

  task automatic check_word(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0d ns: %s expected %h, got %h (record %0d)",
               $time, name, exp, act, current);
    end
  endtask

  task automatic check_record(int i);
    logic [31:0] flags;
    logic [31:0] mask;
    flags = records[i][f_flags];
    mask  = records[i][f_mask];
    // single-bit outputs packed into the flags column
    if (mask[0]) begin
      check_bit("bus_busy_out", flags[0], bus_busy_out);
      check_bit("disp_online", flags[1], disp_online);
      check_bit("next_state", flags[2], next_state);
      check_bit("rst", flags[3], rst);
      check_bit("ext_rst_e", flags[4], ext_rst_e);
      check_bit("ext_next_cpu_e", flags[5], ext_next_cpu_e);
      check_bit("ext_dispatcher_q", flags[6], ext_dispatcher_q);
      check_bit("ext_read_q", flags[7], ext_read_q);
      check_bit("ext_write_q", flags[8], ext_write_q);
    end
    if (mask[1]) begin
      check_word("cpu_ind_rel", records[i][f_rel], 32'(cpu_ind_rel));
    end
    if (mask[2]) begin
      check_word("ext_cpu_msg", records[i][f_exp_msg], 32'(ext_cpu_msg));
    end
    // base addresses have no reset value
    if (mask[3]) begin
      check_word("base_addr", records[i][f_base], base_addr);
      check_word("base_addr_data", records[i][f_base_data], base_addr_data);
    end
  endtask

  initial begin
    ext_rst_b      = 1'b1;
    state          = state_other;
    addr_in        = '0;
    data_in        = '0;
    read_q         = 1'b0;
    write_q        = 1'b0;
    bus_busy_in    = 1'b0;
    ext_cpu_index  = '0;
    ext_next_cpu_q = 1'b0;
    ext_cpu_msg_in = msg_none;
    load_records();
    records_ready = 1'b1;
    for (int i = 0; i < n_records; i++) begin
      current = i;
      @(posedge clk);
      #1;
      drive_record(i);
      // sample just before the next edge
      if (records[i][f_op] == 0) begin
        repeat (reset_cycles - 1) @(posedge clk);
        #3;
      end else begin
        #2;
      end
      check_record(i);
    end
    $display("%0d records, %0d checks, %0d errors", n_records, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // bound scales with the record count
  initial begin
    int limit;
    wait (records_ready);
    limit = (n_records * cycles_per_record + reset_cycles) * clk_period;
    #(limit);
    $display("watchdog expired after %0d ns, the test records did not finish", limit);
    $display("=== FAIL ===");
    $finish;
  end

endmodule
